// File: filelist.f
+incdir+src
+incdir+verification
src/rob_pkg.sv
src/rob_pointers.sv
src/rob_entry_store.sv
src/rob_status.sv
src/rob_commit.sv
src/rob_top.sv
verification/rob_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the reorder buffer testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module rob_tb \
    -f filelist.f -o rob_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/rob_sim > sim.log 2>&1 || { cat sim.log; echo "simulation returned an error"; exit 1; }

grep -q '\*\*\* PASSED \*\*\*' sim.log \
    && { echo "simulation passed"; exit 0; } \
    || { cat sim.log; echo "simulation failed"; exit 1; }

// File: src/rob_commit.sv
`timescale 1ns/1ps
`include "rob_defines.svh"

module rob_commit
    import rob_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  rob_idx_t                   head,
    input  logic [`OCC_WIDTH-1:0]      occupancy,
    input  logic [`COMMIT_WIDTH-1:0]   head_done,
    input  exc_code_t                  head_exccode [`COMMIT_WIDTH],
    input  rob_entry_t                 head_entry [`COMMIT_WIDTH],
    output logic [`LANE_CNT_WIDTH-1:0] commit_num,
    output logic                       flush,
    output logic [`COMMIT_WIDTH-1:0]   commit_valid,
    output logic [`COMMIT_WIDTH-1:0]   commit_we,
    output logic [`AREG_WIDTH-1:0]     commit_vrd [`COMMIT_WIDTH],
    output logic [`PREG_WIDTH-1:0]     commit_prd [`COMMIT_WIDTH],
    output logic [`PREG_WIDTH-1:0]     commit_old_prd [`COMMIT_WIDTH],
    output logic                       redirect_valid,
    output exc_code_t                  redirect_exccode,
    output rob_idx_t                   redirect_rob_idx
);

    logic [`COMMIT_WIDTH-1:0]         lane_live;
    logic [`COMMIT_WIDTH-1:0]         lane_exc;
    logic [`COMMIT_WIDTH-1:0]         eligible;
    logic [`COMMIT_WIDTH-1:0]         fault_hit;
    logic                             chain;
    logic [$clog2(`COMMIT_WIDTH)-1:0] fault_lane;

    for (genvar i = 0; i < `COMMIT_WIDTH; i++) begin : g_lane
        assign lane_live[i] = occupancy > `OCC_WIDTH'(i);
        assign lane_exc[i]  = head_exccode[i] != `EXC_NONE;
    end

    // lanes retire in order, the first blocked lane stops the rest
    always_comb begin
        chain      = 1'b1;
        commit_num = '0;
        fault_lane = '0;
        flush      = 1'b0;
        for (int i = 0; i < `COMMIT_WIDTH; i++) begin
            eligible[i]  = chain && lane_live[i] && head_done[i] && !lane_exc[i];
            fault_hit[i] = chain && lane_live[i] && head_done[i] && lane_exc[i];
            if (eligible[i]) begin
                commit_num = `LANE_CNT_WIDTH'(i + 1);
            end
            if (fault_hit[i] && !flush) begin
                flush      = 1'b1;
                fault_lane = i[$clog2(`COMMIT_WIDTH)-1:0];
            end
            chain = eligible[i];
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            commit_valid   <= '0;
            redirect_valid <= 1'b0;
        end else begin
            commit_valid   <= eligible;
            redirect_valid <= flush;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `COMMIT_WIDTH; i++) begin
            commit_we[i]      <= head_entry[i].we;
            commit_vrd[i]     <= head_entry[i].vrd;
            commit_prd[i]     <= head_entry[i].prd;
            commit_old_prd[i] <= head_entry[i].old_prd;
        end
        if (flush) begin
            redirect_exccode <= head_exccode[fault_lane];
            redirect_rob_idx <= rob_idx_t'(head + `OCC_WIDTH'(fault_lane));
        end
    end

    // retired lanes always form a prefix starting at lane 0
    assert property (@(posedge clk) disable iff (!rst)
        ((commit_valid + 1'b1) & commit_valid) == '0);

    // the flush empties the buffer, so redirects never come back to back
    assert property (@(posedge clk) disable iff (!rst)
        redirect_valid |=> !redirect_valid);

endmodule

// File: src/rob_defines.svh
`ifndef ROB_DEFINES_SVH
`define ROB_DEFINES_SVH

// buffer geometry
`define ROB_SIZE          16
`define ROB_IDX_WIDTH     4

// lanes and ports
`define DISPATCH_WIDTH    2
`define COMMIT_WIDTH      2
`define WB_PORTS          2

// count of lanes taken in one cycle, 0 up to the lane count
`define LANE_CNT_WIDTH    ($clog2(`DISPATCH_WIDTH) + 1)

// occupancy runs 0 to ROB_SIZE, same width as a pointer with its wrap bit
`define OCC_WIDTH         (`ROB_IDX_WIDTH + 1)

// exception codes
`define EXC_WIDTH         4
`define EXC_NONE          {`EXC_WIDTH{1'b1}}

// register file widths
`define PREG_WIDTH        6
`define AREG_WIDTH        5

`endif

// File: src/rob_entry_store.sv
`timescale 1ns/1ps
`include "rob_defines.svh"

module rob_entry_store
    import rob_pkg::*;
(
    input  logic                       clk,
    input  rob_idx_t                   tail,
    input  logic [`DISPATCH_WIDTH-1:0] alloc_en,
    input  rob_entry_t                 alloc_entry [`DISPATCH_WIDTH],
    input  rob_idx_t                   head,
    output rob_entry_t                 head_entry [`COMMIT_WIDTH]
);

    rob_entry_t                mem [`ROB_SIZE];
    logic [`ROB_IDX_WIDTH-1:0] widx [`DISPATCH_WIDTH];
    logic [`ROB_IDX_WIDTH-1:0] ridx [`COMMIT_WIDTH];

    // slot numbers wrap on their own, the direction bit is not needed here
    for (genvar i = 0; i < `DISPATCH_WIDTH; i++) begin : g_widx
        assign widx[i] = tail.idx + `ROB_IDX_WIDTH'(i);
    end

    for (genvar i = 0; i < `COMMIT_WIDTH; i++) begin : g_ridx
        assign ridx[i] = head.idx + `ROB_IDX_WIDTH'(i);
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            if (alloc_en[i]) begin
                mem[widx[i]] <= alloc_entry[i];
            end
        end
    end

    // head lanes are read without a register so commit sees them this cycle
    for (genvar i = 0; i < `COMMIT_WIDTH; i++) begin : g_read
        assign head_entry[i] = mem[ridx[i]];
    end

endmodule

// File: src/rob_pkg.sv
`include "rob_defines.svh"

package rob_pkg;

    // slot index with a direction bit that flips on every wrap
    typedef struct packed {
        logic                      dir;
        logic [`ROB_IDX_WIDTH-1:0] idx;
    } rob_idx_t;

    // per-entry payload written at dispatch
    typedef struct packed {
        logic                   we;
        logic [`AREG_WIDTH-1:0] vrd;
        logic [`PREG_WIDTH-1:0] prd;
        logic [`PREG_WIDTH-1:0] old_prd;
    } rob_entry_t;

    // all ones is EXC_NONE
    typedef logic [`EXC_WIDTH-1:0] exc_code_t;

endpackage

// File: src/rob_pointers.sv
`timescale 1ns/1ps
`include "rob_defines.svh"

module rob_pointers
    import rob_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`LANE_CNT_WIDTH-1:0] alloc_num,
    input  logic [`LANE_CNT_WIDTH-1:0] commit_num,
    input  logic                       flush,
    output rob_idx_t                   head,
    output rob_idx_t                   tail,
    output logic [`OCC_WIDTH-1:0]      occupancy,
    output logic                       dis_ready
);

    rob_idx_t                head_next;
    rob_idx_t                tail_next;
    logic [`OCC_WIDTH-1:0]   occ_next;

    // a full dispatch group must fit, and nothing lands on a flush edge
    assign dis_ready = (occupancy <= `OCC_WIDTH'(`ROB_SIZE - `DISPATCH_WIDTH)) && !flush;

    always_comb begin
        head_next = rob_idx_t'(head + `OCC_WIDTH'(commit_num));
        if (flush) begin
            // everything past the committed lanes is discarded
            tail_next = head_next;
            occ_next  = '0;
        end else begin
            tail_next = rob_idx_t'(tail + `OCC_WIDTH'(alloc_num));
            occ_next  = occupancy + `OCC_WIDTH'(alloc_num) - `OCC_WIDTH'(commit_num);
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            head      <= '0;
            tail      <= '0;
            occupancy <= '0;
        end else begin
            head      <= head_next;
            tail      <= tail_next;
            occupancy <= occ_next;
        end
    end

    // the count stays consistent with the pointers and never overruns the array
    assert property (@(posedge clk) disable iff (!rst)
        (occupancy <= `OCC_WIDTH'(`ROB_SIZE))
        && (occupancy == `OCC_WIDTH'(tail - head)));

endmodule

// File: src/rob_status.sv
`timescale 1ns/1ps
`include "rob_defines.svh"

module rob_status
    import rob_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  rob_idx_t                   tail,
    input  logic [`DISPATCH_WIDTH-1:0] alloc_en,
    input  logic [`WB_PORTS-1:0]       wb_en,
    input  rob_idx_t                   wb_rob_idx [`WB_PORTS],
    input  exc_code_t                  wb_exccode [`WB_PORTS],
    input  rob_idx_t                   head,
    output logic [`COMMIT_WIDTH-1:0]   head_done,
    output exc_code_t                  head_exccode [`COMMIT_WIDTH]
);

    logic [`ROB_SIZE-1:0]      done;
    exc_code_t                 exccode [`ROB_SIZE];
    logic [`ROB_IDX_WIDTH-1:0] aidx [`DISPATCH_WIDTH];
    logic [`ROB_IDX_WIDTH-1:0] ridx [`COMMIT_WIDTH];

    for (genvar i = 0; i < `DISPATCH_WIDTH; i++) begin : g_aidx
        assign aidx[i] = tail.idx + `ROB_IDX_WIDTH'(i);
    end

    for (genvar i = 0; i < `COMMIT_WIDTH; i++) begin : g_ridx
        assign ridx[i] = head.idx + `ROB_IDX_WIDTH'(i);
    end

    // new slots start not done; writebacks only ever name allocated slots
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            done <= '0;
        end else begin
            for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
                if (alloc_en[i]) begin
                    done[aidx[i]] <= 1'b0;
                end
            end
            for (int p = 0; p < `WB_PORTS; p++) begin
                if (wb_en[p]) begin
                    done[wb_rob_idx[p].idx] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < `WB_PORTS; p++) begin
            if (wb_en[p]) begin
                exccode[wb_rob_idx[p].idx] <= wb_exccode[p];
            end
        end
    end

    for (genvar i = 0; i < `COMMIT_WIDTH; i++) begin : g_read
        assign head_done[i]    = done[ridx[i]];
        assign head_exccode[i] = exccode[ridx[i]];
    end

    // each instruction completes through exactly one port
    for (genvar a = 0; a < `WB_PORTS; a++) begin : g_wb_a
        for (genvar b = a + 1; b < `WB_PORTS; b++) begin : g_wb_b
            assert property (@(posedge clk) disable iff (!rst)
                !(wb_en[a] && wb_en[b] && (wb_rob_idx[a].idx == wb_rob_idx[b].idx)));
        end
    end

endmodule

// File: src/rob_top.sv
`timescale 1ns/1ps
`include "rob_defines.svh"

module rob_top
    import rob_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`DISPATCH_WIDTH-1:0] dis_valid,
    input  logic [`DISPATCH_WIDTH-1:0] dis_we,
    input  logic [`AREG_WIDTH-1:0]     dis_vrd [`DISPATCH_WIDTH],
    input  logic [`PREG_WIDTH-1:0]     dis_prd [`DISPATCH_WIDTH],
    input  logic [`PREG_WIDTH-1:0]     dis_old_prd [`DISPATCH_WIDTH],
    output logic                       dis_ready,
    output rob_idx_t                   dis_rob_idx,
    input  logic [`WB_PORTS-1:0]       wb_en,
    input  rob_idx_t                   wb_rob_idx [`WB_PORTS],
    input  exc_code_t                  wb_exccode [`WB_PORTS],
    output logic [`COMMIT_WIDTH-1:0]   commit_valid,
    output logic [`COMMIT_WIDTH-1:0]   commit_we,
    output logic [`AREG_WIDTH-1:0]     commit_vrd [`COMMIT_WIDTH],
    output logic [`PREG_WIDTH-1:0]     commit_prd [`COMMIT_WIDTH],
    output logic [`PREG_WIDTH-1:0]     commit_old_prd [`COMMIT_WIDTH],
    output logic                       redirect_valid,
    output exc_code_t                  redirect_exccode,
    output rob_idx_t                   redirect_rob_idx
);

    rob_idx_t                   head;
    rob_idx_t                   tail;
    logic [`OCC_WIDTH-1:0]      occupancy;
    logic [`LANE_CNT_WIDTH-1:0] commit_num;
    logic                       flush;
    logic [`DISPATCH_WIDTH-1:0] alloc_en;
    logic [`LANE_CNT_WIDTH-1:0] alloc_num;
    rob_entry_t                 alloc_entry [`DISPATCH_WIDTH];
    rob_entry_t                 head_entry [`COMMIT_WIDTH];
    logic [`COMMIT_WIDTH-1:0]   head_done;
    exc_code_t                  head_exccode [`COMMIT_WIDTH];

    assign dis_rob_idx = tail;

    // accepted lanes, one shared ready for the whole group
    assign alloc_en = dis_valid & {`DISPATCH_WIDTH{dis_ready}};

    always_comb begin
        alloc_num = '0;
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            alloc_num = alloc_num + `LANE_CNT_WIDTH'(alloc_en[i]);
        end
    end

    for (genvar i = 0; i < `DISPATCH_WIDTH; i++) begin : g_pack
        assign alloc_entry[i] = '{we: dis_we[i], vrd: dis_vrd[i], prd: dis_prd[i],
                                  old_prd: dis_old_prd[i]};
    end

    rob_pointers u_pointers (
        .clk        (clk),
        .rst        (rst),
        .alloc_num  (alloc_num),
        .commit_num (commit_num),
        .flush      (flush),
        .head       (head),
        .tail       (tail),
        .occupancy  (occupancy),
        .dis_ready  (dis_ready)
    );

    rob_entry_store u_entry_store (
        .clk         (clk),
        .tail        (tail),
        .alloc_en    (alloc_en),
        .alloc_entry (alloc_entry),
        .head        (head),
        .head_entry  (head_entry)
    );

    rob_status u_status (
        .clk          (clk),
        .rst          (rst),
        .tail         (tail),
        .alloc_en     (alloc_en),
        .wb_en        (wb_en),
        .wb_rob_idx   (wb_rob_idx),
        .wb_exccode   (wb_exccode),
        .head         (head),
        .head_done    (head_done),
        .head_exccode (head_exccode)
    );

    rob_commit u_commit (
        .clk              (clk),
        .rst              (rst),
        .head             (head),
        .occupancy        (occupancy),
        .head_done        (head_done),
        .head_exccode     (head_exccode),
        .head_entry       (head_entry),
        .commit_num       (commit_num),
        .flush            (flush),
        .commit_valid     (commit_valid),
        .commit_we        (commit_we),
        .commit_vrd       (commit_vrd),
        .commit_prd       (commit_prd),
        .commit_old_prd   (commit_old_prd),
        .redirect_valid   (redirect_valid),
        .redirect_exccode (redirect_exccode),
        .redirect_rob_idx (redirect_rob_idx)
    );

endmodule

// File: verification/rob_tb_table.svh
`ifndef ROB_TB_TABLE_SVH
`define ROB_TB_TABLE_SVH

typedef struct {
    int        count;
    int        base;
    int        fault_pos;
    exc_code_t code;
    bit        expect_full;
    int        exp_commits;
    bit        exp_redirect;
} row_t;

localparam int NUM_ROWS = 9;

row_t rows [NUM_ROWS];

task automatic load_table();
    // count, payload base, faulting instruction (-1 none), code, fills the buffer,
    // expected commits, expected redirect
    rows[0] = '{4, 1, -1, `EXC_NONE, 1'b0, 4, 1'b0};
    rows[1] = '{7, 2, -1, `EXC_NONE, 1'b0, 7, 1'b0};
    // sixteen with no writeback until the buffer is full, wraps the tail
    rows[2] = '{16, 3, -1, `EXC_NONE, 1'b1, 16, 1'b0};
    rows[3] = '{5, 4, 2, 4'h3, 1'b0, 2, 1'b1};
    // fault at the very head, nothing retires
    rows[4] = '{6, 5, 0, 4'h5, 1'b0, 0, 1'b1};
    rows[5] = '{9, 6, -1, `EXC_NONE, 1'b0, 9, 1'b0};
    rows[6] = '{12, 7, 11, 4'h0, 1'b0, 11, 1'b1};
    rows[7] = '{16, 8, 15, 4'h7, 1'b1, 15, 1'b1};
    rows[8] = '{3, 9, -1, `EXC_NONE, 1'b0, 3, 1'b0};
endtask

`endif

// File: verification/rob_tb.sv
`timescale 1ns/1ps
`include "rob_defines.svh"

module rob_tb
    import rob_pkg::*;
();

    logic                       clk;
    logic                       rst;
    logic [`DISPATCH_WIDTH-1:0] dis_valid;
    logic [`DISPATCH_WIDTH-1:0] dis_we;
    logic [`AREG_WIDTH-1:0]     dis_vrd [`DISPATCH_WIDTH];
    logic [`PREG_WIDTH-1:0]     dis_prd [`DISPATCH_WIDTH];
    logic [`PREG_WIDTH-1:0]     dis_old_prd [`DISPATCH_WIDTH];
    logic                       dis_ready;
    rob_idx_t                   dis_rob_idx;
    logic [`WB_PORTS-1:0]       wb_en;
    rob_idx_t                   wb_rob_idx [`WB_PORTS];
    exc_code_t                  wb_exccode [`WB_PORTS];
    logic [`COMMIT_WIDTH-1:0]   commit_valid;
    logic [`COMMIT_WIDTH-1:0]   commit_we;
    logic [`AREG_WIDTH-1:0]     commit_vrd [`COMMIT_WIDTH];
    logic [`PREG_WIDTH-1:0]     commit_prd [`COMMIT_WIDTH];
    logic [`PREG_WIDTH-1:0]     commit_old_prd [`COMMIT_WIDTH];
    logic                       redirect_valid;
    exc_code_t                  redirect_exccode;
    rob_idx_t                   redirect_rob_idx;

    // reference model state
    rob_entry_t                 model_q [$];
    logic [`ROB_IDX_WIDTH:0]    exp_tail;
    logic [`ROB_IDX_WIDTH:0]    slot_idx [`ROB_SIZE];

    `include "rob_tb_table.svh"

    rob_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL time=%0t signal=%s got=%0h expected=%0h", $time, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("timeout at %0t: %s", $time, what);
        $display("*** FAILED ***");
        $fatal(1, "timeout");
    endtask

    function automatic rob_entry_t payload_of(input int base, input int k);
        rob_entry_t e;
        e.we      = (k % 3) != 0;
        e.vrd     = `AREG_WIDTH'(base * 3 + k);
        e.prd     = `PREG_WIDTH'(base * 11 + 2 * k);
        e.old_prd = `PREG_WIDTH'(base * 7 + 5 * k + 1);
        return e;
    endfunction

    // everything from the faulting instruction on is discarded
    task automatic build_model(input int r);
        model_q.delete();
        for (int k = 0; k < rows[r].count; k++) begin
            if (rows[r].fault_pos < 0 || k < rows[r].fault_pos) begin
                model_q.push_back(payload_of(rows[r].base, k));
            end
        end
    endtask

    task automatic dispatch_row(input int r);
        int         k;
        int         lanes;
        int         waited;
        rob_entry_t e;
        k = 0;
        while (k < rows[r].count) begin
            waited = 0;
            while (!dis_ready) begin
                @(negedge clk);
                waited++;
                if (waited > 50) fail_timeout("dis_ready stayed low during dispatch");
            end
            check_value("dis_rob_idx", 32'(dis_rob_idx), 32'(exp_tail));
            lanes = (rows[r].count - k >= 2) ? 2 : 1;
            for (int l = 0; l < `DISPATCH_WIDTH; l++) begin
                e = payload_of(rows[r].base, k + l);
                dis_valid[l]   = l < lanes;
                dis_we[l]      = e.we;
                dis_vrd[l]     = e.vrd;
                dis_prd[l]     = e.prd;
                dis_old_prd[l] = e.old_prd;
                if (l < lanes) slot_idx[k + l] = exp_tail + (`ROB_IDX_WIDTH + 1)'(l);
            end
            exp_tail = exp_tail + (`ROB_IDX_WIDTH + 1)'(lanes);
            k += lanes;
            @(negedge clk);
            dis_valid = '0;
        end
    endtask

    // completion order is random and stops once the fault and all older entries are done
    task automatic writeback_row(input int r);
        int order [$];
        int pick;
        int tmp;
        int cut;
        int older;
        int i;
        for (int k = 0; k < rows[r].count; k++) order.push_back(k);
        for (int k = rows[r].count - 1; k > 0; k--) begin
            pick = int'($urandom % (k + 1));
            tmp = order[k];
            order[k] = order[pick];
            order[pick] = tmp;
        end
        cut = rows[r].count;
        older = 0;
        if (rows[r].fault_pos >= 0) begin
            for (int k = 0; k < rows[r].count && cut == rows[r].count; k++) begin
                if (order[k] <= rows[r].fault_pos) older++;
                if (older == rows[r].fault_pos + 1) cut = k + 1;
            end
        end
        i = 0;
        while (i < cut) begin
            for (int p = 0; p < `WB_PORTS; p++) begin
                if (i < cut) begin
                    wb_en[p]      = 1'b1;
                    wb_rob_idx[p] = rob_idx_t'(slot_idx[order[i]]);
                    wb_exccode[p] = (order[i] == rows[r].fault_pos) ? rows[r].code : `EXC_NONE;
                    i++;
                end
            end
            @(negedge clk);
            wb_en = '0;
            repeat ($urandom % 3) @(negedge clk);
        end
    endtask

    task automatic sample_outputs(input int r, inout int commits, inout int redirects);
        rob_entry_t e;
        for (int l = 0; l < `COMMIT_WIDTH; l++) begin
            if (commit_valid[l]) begin
                if (model_q.size() == 0) check_value($sformatf("commit_valid[%0d]", l), 1, 0);
                e = model_q.pop_front();
                check_value($sformatf("commit_we[%0d]", l), 32'(commit_we[l]), 32'(e.we));
                check_value($sformatf("commit_vrd[%0d]", l), 32'(commit_vrd[l]), 32'(e.vrd));
                check_value($sformatf("commit_prd[%0d]", l), 32'(commit_prd[l]), 32'(e.prd));
                check_value($sformatf("commit_old_prd[%0d]", l), 32'(commit_old_prd[l]),
                            32'(e.old_prd));
                commits++;
            end
        end
        if (redirect_valid) begin
            check_value("redirect_valid", 1, 32'(rows[r].exp_redirect && redirects == 0));
            check_value("redirect_exccode", 32'(redirect_exccode), 32'(rows[r].code));
            check_value("redirect_rob_idx", 32'(redirect_rob_idx),
                        32'(slot_idx[rows[r].fault_pos]));
            redirects++;
        end
    endtask

    task automatic watch_commits(input int r);
        int cycles;
        int commits;
        int redirects;
        cycles = 0;
        commits = 0;
        redirects = 0;
        while (commits < rows[r].exp_commits || redirects < int'(rows[r].exp_redirect)) begin
            @(negedge clk);
            cycles++;
            if (cycles > 400) fail_timeout("commits or redirect did not arrive");
            sample_outputs(r, commits, redirects);
        end
        // discarded entries must stay silent afterwards
        repeat (4) begin
            @(negedge clk);
            sample_outputs(r, commits, redirects);
        end
        check_value("commit count", commits, rows[r].exp_commits);
        check_value("redirect count", redirects, 32'(rows[r].exp_redirect));
        check_value("uncommitted model entries", model_q.size(), 0);
    endtask

    initial begin
        void'($urandom(32'hdd10));
        rst = 1'b0;
        dis_valid = '0;
        dis_we = '0;
        wb_en = '0;
        for (int l = 0; l < `DISPATCH_WIDTH; l++) begin
            dis_vrd[l] = '0;
            dis_prd[l] = '0;
            dis_old_prd[l] = '0;
        end
        for (int p = 0; p < `WB_PORTS; p++) begin
            wb_rob_idx[p] = '0;
            wb_exccode[p] = `EXC_NONE;
        end
        exp_tail = '0;
        load_table();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        check_value("commit_valid", 32'(commit_valid), 0);
        check_value("redirect_valid", 32'(redirect_valid), 0);
        check_value("dis_ready", 32'(dis_ready), 1);
        check_value("dis_rob_idx", 32'(dis_rob_idx), 0);
        for (int r = 0; r < NUM_ROWS; r++) begin
            build_model(r);
            dispatch_row(r);
            if (rows[r].expect_full) check_value("dis_ready when full", 32'(dis_ready), 0);
            fork
                writeback_row(r);
                watch_commits(r);
            join
            if (rows[r].fault_pos >= 0) exp_tail = slot_idx[rows[r].fault_pos];
            check_value("dis_ready after row", 32'(dis_ready), 1);
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule
